// ==== logic/rvPkg.sv ====
package rvPkg;

	localparam int XLEN = 32;

	// major opcodes
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [31:0] ebreakWord = 32'h0010_0073;

	// funct3, alu group
	localparam logic [2:0] f3AddSub = 3'd0;
	localparam logic [2:0] f3Sll    = 3'd1;
	localparam logic [2:0] f3Slt    = 3'd2;
	localparam logic [2:0] f3Sltu   = 3'd3;
	localparam logic [2:0] f3Xor    = 3'd4;
	localparam logic [2:0] f3Srl    = 3'd5; // srl and sra
	localparam logic [2:0] f3Or     = 3'd6;
	localparam logic [2:0] f3And    = 3'd7;

	// funct3, loads and stores
	localparam logic [2:0] f3Byte  = 3'd0;
	localparam logic [2:0] f3Half  = 3'd1;
	localparam logic [2:0] f3Word  = 3'd2;
	localparam logic [2:0] f3ByteU = 3'd4;
	localparam logic [2:0] f3HalfU = 3'd5;

	localparam logic [2:0] f3Beq  = 3'd0;
	localparam logic [2:0] f3Jalr = 3'd0;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

endpackage

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

	// register write source, also driven out as memToReg
	typedef enum logic [1:0] {
		wbAlu   = 2'd0,
		wbMem   = 2'd1,
		wbPc4   = 2'd2,
		wbPcImm = 2'd3
	} wbSrcT;

	typedef enum logic [1:0] {
		pcSelPlus4   = 2'd0,
		pcSelBranch  = 2'd1, // pc + imm, beq and jal
		pcSelJumpReg = 2'd2, // jalr
		pcSelHold    = 2'd3
	} pcSrcT;

	// 2'd2 unused
	typedef enum logic [1:0] {
		lenByte = 2'd0,
		lenHalf = 2'd1,
		lenWord = 2'd3
	} dataLenT;

endpackage

// ==== logic/ctrlIf.sv ====
`timescale 1ns/100ps

interface ctrlIf import rvPkg::*; import ctrlPkg::*; ();

	aluOpT           aluOp;
	logic            aluSrcImm;
	logic            regWrite;
	wbSrcT           wbSrc;
	logic            memWrite;
	dataLenT         dataLen;
	logic            dataSign;  // 1 for lb, lh
	logic            branch;
	logic [1:0]      jump;      // 01 jal, 10 jalr
	logic [XLEN-1:0] imm;

	modport dec(
		output aluOp, aluSrcImm, regWrite, wbSrc, memWrite,
		output dataLen, dataSign, branch, jump, imm
	);

	// imm also feeds the second alu operand
	modport alu(input aluOp, aluSrcImm, imm);

	modport wb(input wbSrc, dataSign, dataLen);

	modport pc(input branch, jump, imm);

endinterface

// ==== logic/decoder.sv ====
`timescale 1ns/100ps

module decoder import rvPkg::*; import ctrlPkg::*; (
	input  logic [XLEN-1:0] inst,
	input  logic            rst,
	ctrlIf.dec              ctrl,
	output logic            invalid,
	output logic            ebreak
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic            legal;
	logic [XLEN-1:0] immI;
	logic [XLEN-1:0] immS;
	logic [XLEN-1:0] immB;
	logic [XLEN-1:0] immU;
	logic [XLEN-1:0] immJ;

	function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			f3AddSub: return alt ? aluSub : aluAdd;
			f3Sll:    return aluSll;
			f3Slt:    return aluSlt;
			f3Sltu:   return aluSltu;
			f3Xor:    return aluXor;
			f3Srl:    return alt ? aluSra : aluSrl;
			f3Or:     return aluOr;
			f3And:    return aluAnd;
			default:  return aluAdd;
		endcase
	endfunction

	function automatic dataLenT memLen(input logic [2:0] f3);
		case (f3)
			f3Byte, f3ByteU: return lenByte;
			f3Half, f3HalfU: return lenHalf;
			default:         return lenWord;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{(XLEN-12){inst[31]}}, inst[31:20]};
	assign immS = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// no immediate shifts in the supported subset
	always_comb begin
		case (opcode)
			opLui, opAuipc, opJal: legal = 1'b1;
			opJalr:   legal = (funct3 == f3Jalr);
			opBranch: legal = (funct3 == f3Beq);
			opLoad:   legal = funct3 inside {f3Byte, f3Half, f3Word, f3ByteU, f3HalfU};
			opStore:  legal = funct3 inside {f3Byte, f3Half, f3Word};
			opImm:    legal = !(funct3 inside {f3Sll, f3Srl});
			opReg:    legal = (funct7 == 7'h00) ||
				(funct7 == 7'h20 && funct3 inside {f3AddSub, f3Srl});
			opSystem: legal = (inst == ebreakWord);
			default:  legal = 1'b0;
		endcase
	end

	assign invalid = !legal;
	assign ebreak = (inst == ebreakWord);

	always_comb begin
		ctrl.aluOp = aluAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.wbSrc = wbAlu;
		ctrl.memWrite = 1'b0;
		ctrl.dataLen = lenWord;
		ctrl.dataSign = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.jump = 2'b00;
		ctrl.imm = immI;
		case (opcode)
			opLui: begin
				ctrl.aluOp = aluPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immU;
				ctrl.regWrite = 1'b1;
			end
			opAuipc: begin
				ctrl.imm = immU;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSrc = wbPcImm; // pc + imm from the pc adder
			end
			opJal: begin
				ctrl.imm = immJ;
				ctrl.regWrite = 1'b1;
				ctrl.wbSrc = wbPc4;
				ctrl.jump = 2'b01;
			end
			opJalr: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSrc = wbPc4;
				ctrl.jump = 2'b10;
			end
			opBranch: begin
				ctrl.imm = immB;
				ctrl.aluOp = aluSub; // zero flag decides
				ctrl.branch = 1'b1;
			end
			opLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSrc = wbMem;
				ctrl.dataLen = memLen(funct3);
				ctrl.dataSign = !funct3[2];
			end
			opStore: begin
				ctrl.imm = immS;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.dataLen = memLen(funct3);
			end
			opImm: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluFromFunct(funct3, 1'b0);
			end
			opReg: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluFromFunct(funct3, funct7[5]);
			end
			default: ;
		endcase
		if (rst || invalid || ebreak) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
		end
	end

endmodule

// ==== logic/pcCounter.sv ====
`timescale 1ns/100ps

module pcCounter import rvPkg::*; import ctrlPkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
	input  logic            clk,
	input  logic            rst,
	ctrlIf.pc               ctrl,
	input  logic            zero,
	input  logic [XLEN-1:0] aluResult,
	input  logic            halt,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] pcPlus4,
	output logic [XLEN-1:0] pcTarget
);

	pcSrcT           pcSrc;
	logic [XLEN-1:0] pcNext;

	assign pcPlus4 = pc + XLEN'(4);
	assign pcTarget = pc + ctrl.imm;

	always_comb begin
		if (halt)
			pcSrc = pcSelHold;
		else if (ctrl.jump[1])
			pcSrc = pcSelJumpReg;
		else if (ctrl.jump[0] || (ctrl.branch && zero))
			pcSrc = pcSelBranch;
		else
			pcSrc = pcSelPlus4;
	end

	always_comb begin
		case (pcSrc)
			pcSelBranch:  pcNext = pcTarget;
			pcSelJumpReg: pcNext = {aluResult[XLEN-1:1], 1'b0}; // jalr drops bit 0
			pcSelHold:    pcNext = pc;
			default:      pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else
			pc <= pcNext;
	end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/100ps

module regFile import rvPkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic            we,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads zero even before the first reset
	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu import rvPkg::*; (
	ctrlIf.alu              ctrl,
	input  logic [XLEN-1:0] srcA,
	input  logic [XLEN-1:0] rs2Data,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	logic [XLEN-1:0] srcB;
	logic [4:0]      shamt;

	assign srcB = ctrl.aluSrcImm ? ctrl.imm : rs2Data;
	assign shamt = srcB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   result = srcA + srcB;
			aluSub:   result = srcA - srcB;
			aluSll:   result = srcA << shamt;
			aluSlt:   result = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			aluSltu:  result = {{(XLEN-1){1'b0}}, srcA < srcB};
			aluXor:   result = srcA ^ srcB;
			aluSrl:   result = srcA >> shamt;
			aluSra:   result = $signed(srcA) >>> shamt;
			aluOr:    result = srcA | srcB;
			aluAnd:   result = srcA & srcB;
			aluPassB: result = srcB; // lui
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== logic/writeBack.sv ====
`timescale 1ns/100ps

module writeBack import rvPkg::*; import ctrlPkg::*; (
	ctrlIf.wb               ctrl,
	input  logic [XLEN-1:0] aluResult,
	input  logic [XLEN-1:0] readData,
	input  logic [XLEN-1:0] pcPlus4,
	input  logic [XLEN-1:0] pcTarget,
	output logic [XLEN-1:0] wdata
);

	logic [XLEN-1:0] loadData;

	// memory returns the addressed bytes in the low lanes
	always_comb begin
		case (ctrl.dataLen)
			lenByte: loadData = {{(XLEN-8){ctrl.dataSign & readData[7]}}, readData[7:0]};
			lenHalf: loadData = {{(XLEN-16){ctrl.dataSign & readData[15]}}, readData[15:0]};
			default: loadData = readData;
		endcase
	end

	always_comb begin
		case (ctrl.wbSrc)
			wbMem:   wdata = loadData;
			wbPc4:   wdata = pcPlus4;  // link value
			wbPcImm: wdata = pcTarget; // auipc
			default: wdata = aluResult;
		endcase
	end

endmodule

// ==== logic/rvCore.sv ====
`timescale 1ns/100ps

module rvCore import rvPkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [XLEN-1:0] inst,
	input  logic [XLEN-1:0] readData,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] aluResult,
	output logic [XLEN-1:0] storeData,
	output logic [1:0]      dataLen,   // 0 byte, 1 half, 3 word
	output logic            memWrite,
	output logic [1:0]      memToReg,
	output logic            invalid,
	output logic            ebreak
);

	ctrlIf ctrl();

	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic [XLEN-1:0] wdata;
	logic [XLEN-1:0] pcPlus4;
	logic [XLEN-1:0] pcTarget;
	logic            zero;

	decoder decoder_i (
		.inst    (inst),
		.rst     (rst),
		.ctrl    (ctrl),
		.invalid (invalid),
		.ebreak  (ebreak)
	);

	pcCounter #(.RESET_PC(RESET_PC)) pcCounter_i (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.zero      (zero),
		.aluResult (aluResult),
		.halt      (ebreak),
		.pc        (pc),
		.pcPlus4   (pcPlus4),
		.pcTarget  (pcTarget)
	);

	regFile regFile_i (
		.clk    (clk),
		.rst    (rst),
		.rs1    (inst[19:15]),
		.rs2    (inst[24:20]),
		.rd     (inst[11:7]),
		.we     (ctrl.regWrite),
		.wdata  (wdata),
		.rdata1 (rs1Data),
		.rdata2 (rs2Data)
	);

	alu alu_i (
		.ctrl    (ctrl),
		.srcA    (rs1Data),
		.rs2Data (rs2Data),
		.result  (aluResult),
		.zero    (zero)
	);

	writeBack writeBack_i (
		.ctrl      (ctrl),
		.aluResult (aluResult),
		.readData  (readData),
		.pcPlus4   (pcPlus4),
		.pcTarget  (pcTarget),
		.wdata     (wdata)
	);

	assign storeData = rs2Data;
	assign dataLen = ctrl.dataLen;
	assign memWrite = ctrl.memWrite;
	assign memToReg = ctrl.wbSrc;

endmodule

// ==== tb/rvCore_props.sv ====
`timescale 1ns/100ps

module rvCore_props import rvPkg::*; (
	input logic            clk,
	input logic            rst,
	input logic [XLEN-1:0] pc,
	input logic            memWrite,
	input logic            ebreak
);

	int assertFails = 0; // read by the testbench at the end

	noStoreInReset: assert property (@(posedge clk) rst |-> !memWrite)
		else begin
			$error("memWrite high while rst is asserted");
			assertFails++;
		end

	// once halted only reset releases the core
	ebreakSticky: assert property (@(posedge clk) (ebreak && !rst) |=> (ebreak || rst))
		else begin
			$error("ebreak dropped without reset");
			assertFails++;
		end

	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else begin
			$error("pc not word aligned");
			assertFails++;
		end

endmodule

// ==== tb/coreChecker.sv ====
`timescale 1ns/100ps

module coreChecker import rvPkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [XLEN-1:0] inst,
	input  logic [XLEN-1:0] readData,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] aluResult,
	input  logic [XLEN-1:0] storeData,
	input  logic [1:0]      dataLen,
	input  logic            memWrite,
	input  logic [1:0]      memToReg,
	input  logic            invalid,
	input  logic            ebreak,
	output int              errorCount
);

	typedef struct {
		logic [XLEN-1:0] pcNext;
		logic [XLEN-1:0] aluResult;
		logic [XLEN-1:0] storeData;
		logic [XLEN-1:0] wdata;
		logic [1:0]      dataLen;
		logic [1:0]      memToReg;
		logic            memWrite;
		logic            regWrite;
		logic            invalid;
		logic            ebreak;
		logic            aluUsed;  // aluResult is architecturally meaningful
		logic            isLoad;
	} expectT;

	logic [XLEN-1:0] regs [32];
	logic [XLEN-1:0] pcModel;
	logic            resetSeen = 1'b0;
	expectT          want;
	int              errors = 0;

	assign errorCount = errors;

	function automatic logic [XLEN-1:0] isaArith(input logic [2:0] f3, input logic alt,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic [1:0] sizeCode(input logic [2:0] f3);
		case (f3[1:0])
			2'd0: return 2'd0;
			2'd1: return 2'd1;
			default: return 2'd3;
		endcase
	endfunction

	// one instruction of the architectural model
	function automatic expectT predict(input logic [XLEN-1:0] in, input logic [XLEN-1:0] rdata,
			input logic [XLEN-1:0] pcNow);
		expectT          e;
		logic [2:0]      f3;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] immI;
		logic [XLEN-1:0] immS;
		logic [XLEN-1:0] immB;
		logic [XLEN-1:0] immU;
		logic [XLEN-1:0] immJ;
		logic            legal;
		f3 = in[14:12];
		a = regs[in[19:15]];
		b = regs[in[24:20]];
		immI = {{20{in[31]}}, in[31:20]};
		immS = {{20{in[31]}}, in[31:25], in[11:7]};
		immB = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
		immU = {in[31:12], 12'h000};
		immJ = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
		e.pcNext = pcNow + 32'd4;
		e.aluResult = '0;
		e.storeData = b;
		e.wdata = '0;
		e.dataLen = 2'd3;
		e.memToReg = 2'd0;
		e.memWrite = 1'b0;
		e.regWrite = 1'b0;
		e.aluUsed = 1'b1;
		e.isLoad = 1'b0;
		legal = 1'b1;
		case (in[6:0])
			opLui: begin
				e.aluResult = immU;
				e.wdata = immU;
				e.regWrite = 1'b1;
			end
			opAuipc: begin
				e.wdata = pcNow + immU;
				e.memToReg = 2'd3;
				e.regWrite = 1'b1;
				e.aluUsed = 1'b0;
			end
			opJal: begin
				e.pcNext = pcNow + immJ;
				e.wdata = pcNow + 32'd4;
				e.memToReg = 2'd2;
				e.regWrite = 1'b1;
				e.aluUsed = 1'b0;
			end
			opJalr: begin
				legal = (f3 == 3'd0);
				e.aluResult = a + immI;
				e.pcNext = e.aluResult & ~32'd1;
				e.wdata = pcNow + 32'd4;
				e.memToReg = 2'd2;
				e.regWrite = 1'b1;
			end
			opBranch: begin
				legal = (f3 == 3'd0); // beq only
				e.aluResult = a - b;
				if (a == b)
					e.pcNext = pcNow + immB;
			end
			opLoad: begin
				legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
				e.aluResult = a + immI;
				e.memToReg = 2'd1;
				e.dataLen = sizeCode(f3);
				e.regWrite = 1'b1;
				e.isLoad = 1'b1;
				case (f3)
					3'd0: e.wdata = {{24{rdata[7]}}, rdata[7:0]};
					3'd1: e.wdata = {{16{rdata[15]}}, rdata[15:0]};
					3'd4: e.wdata = {24'h0, rdata[7:0]};
					3'd5: e.wdata = {16'h0, rdata[15:0]};
					default: e.wdata = rdata;
				endcase
			end
			opStore: begin
				legal = f3 inside {3'd0, 3'd1, 3'd2};
				e.aluResult = a + immS;
				e.dataLen = sizeCode(f3);
				e.memWrite = 1'b1;
			end
			opImm: begin
				legal = !(f3 == 3'd1 || f3 == 3'd5);
				e.aluResult = isaArith(f3, 1'b0, a, immI);
				e.wdata = e.aluResult;
				e.regWrite = 1'b1;
			end
			opReg: begin
				legal = (in[31:25] == 7'h00) || (in[31:25] == 7'h20 && f3 inside {3'd0, 3'd5});
				e.aluResult = isaArith(f3, in[30], a, b);
				e.wdata = e.aluResult;
				e.regWrite = 1'b1;
			end
			opSystem: legal = (in == ebreakWord);
			default:  legal = 1'b0;
		endcase
		e.invalid = !legal;
		e.ebreak = (in == ebreakWord);
		if (e.ebreak) begin
			e.pcNext = pcNow; // halted
			e.aluUsed = 1'b0;
		end
		if (!legal || e.ebreak) begin
			e.regWrite = 1'b0;
			e.memWrite = 1'b0;
			e.aluUsed = 1'b0;
			e.isLoad = 1'b0;
		end
		return e;
	endfunction

	task automatic compareValue(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] = '0;
			pcModel = RESET_PC;
			resetSeen = 1'b1;
		end else if (resetSeen) begin
			want = predict(inst, readData, pcModel);
			compareValue("pc", pc, pcModel);
			compareValue("invalid", invalid, want.invalid);
			compareValue("ebreak", ebreak, want.ebreak);
			compareValue("memWrite", memWrite, want.memWrite);
			compareValue("memToReg", memToReg, want.memToReg);
			if (want.aluUsed)
				compareValue("aluResult", aluResult, want.aluResult);
			if (want.memWrite) begin
				compareValue("storeData", storeData, want.storeData);
				compareValue("dataLen", dataLen, want.dataLen);
			end
			if (want.isLoad)
				compareValue("dataLen", dataLen, want.dataLen);
			if (want.regWrite && inst[11:7] != 5'd0)
				regs[inst[11:7]] = want.wdata;
			pcModel = want.pcNext;
		end
	end

endmodule

// ==== tb/rvCore_tb.sv ====
`timescale 1ns/100ps

module rvCore_tb import rvPkg::*; ();

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
	localparam int randomCount = 40;

	logic            clk;
	logic            rst;
	logic [XLEN-1:0] inst;
	logic [XLEN-1:0] readData;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] storeData;
	logic [1:0]      dataLen;
	logic            memWrite;
	logic [1:0]      memToReg;
	logic            invalid;
	logic            ebreak;
	int              errorCount;

	logic [XLEN-1:0] imem [$];
	logic [7:0]      dmem [256];
	int              seed = 86;

	rvCore #(.RESET_PC(RESET_PC)) dut_i (.*);

	coreChecker #(.RESET_PC(RESET_PC)) checker_i (.*);

	bind rvCore rvCore_props props_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [2:0] f3, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'd0, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [6:0] op, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// non-control instructions only, memory accesses based on x0
	function automatic logic [31:0] randomInst();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] offs;
		r = $random(seed);
		f3 = r[25:23];
		offs = {4'h0, r[22:15]};
		case ($unsigned($random(seed)) % 6)
			0: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					f3 = 3'd0;
				return iType(opImm, f3, r[4:0], r[9:5], r[31:20]);
			end
			1: begin
				f7 = (r[26] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
				return rType(f7, f3, r[4:0], r[9:5], r[14:10]);
			end
			2: return uType(opLui, r[4:0], r[31:12]);
			3: return uType(opAuipc, r[4:0], r[31:12]);
			4: begin
				if (!(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}))
					f3 = 3'd2;
				if (f3[1:0] == 2'd2)
					offs[1:0] = 2'b00;
				else if (f3[1:0] == 2'd1)
					offs[0] = 1'b0;
				return iType(opLoad, f3, r[4:0], 5'd0, offs);
			end
			default: begin
				f3 = (r[24:23] == 2'd3) ? 3'd2 : {1'b0, r[24:23]};
				if (f3 == 3'd2)
					offs[1:0] = 2'b00;
				else if (f3 == 3'd1)
					offs[0] = 1'b0;
				return sType(f3, r[14:10], 5'd0, offs);
			end
		endcase
	endfunction

	task automatic loadProgram();
		int base;
		imem.push_back(sType(3'd2, 5'd0, 5'd0, 12'd0)); // fetched while rst is high
		imem.push_back(iType(opImm, 3'd0, 5'd1, 5'd0, 12'd5));
		imem.push_back(iType(opImm, 3'd0, 5'd2, 5'd0, 12'hffd)); // -3
		imem.push_back(rType(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
		imem.push_back(rType(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
		imem.push_back(rType(7'h00, 3'd2, 5'd5, 5'd2, 5'd1));
		imem.push_back(rType(7'h00, 3'd3, 5'd6, 5'd2, 5'd1));
		imem.push_back(iType(opImm, 3'd2, 5'd7, 5'd2, 12'hfff));
		imem.push_back(iType(opImm, 3'd3, 5'd8, 5'd1, 12'd7));
		imem.push_back(iType(opImm, 3'd4, 5'd9, 5'd1, 12'h0ff));
		imem.push_back(iType(opImm, 3'd6, 5'd10, 5'd2, 12'h0f0));
		imem.push_back(iType(opImm, 3'd7, 5'd11, 5'd2, 12'h7f0));
		imem.push_back(rType(7'h00, 3'd1, 5'd12, 5'd1, 5'd4)); // shift by 8
		imem.push_back(rType(7'h00, 3'd5, 5'd13, 5'd2, 5'd1));
		imem.push_back(rType(7'h20, 3'd5, 5'd14, 5'd2, 5'd1));
		imem.push_back(rType(7'h00, 3'd4, 5'd15, 5'd1, 5'd2));
		imem.push_back(rType(7'h00, 3'd6, 5'd16, 5'd1, 5'd12));
		imem.push_back(rType(7'h00, 3'd7, 5'd17, 5'd2, 5'd12));
		imem.push_back(uType(opLui, 5'd18, 20'h12345));
		imem.push_back(uType(opAuipc, 5'd19, 20'h00001));
		imem.push_back(rType(7'h00, 3'd0, 5'd20, 5'd19, 5'd18));
		imem.push_back(iType(opImm, 3'd0, 5'd0, 5'd1, 12'd7)); // x0 stays zero
		imem.push_back(rType(7'h00, 3'd0, 5'd20, 5'd0, 5'd1));
		imem.push_back(sType(3'd2, 5'd2, 5'd0, 12'd16));
		imem.push_back(sType(3'd1, 5'd12, 5'd0, 12'd20));
		imem.push_back(sType(3'd0, 5'd1, 5'd0, 12'd23));
		imem.push_back(iType(opLoad, 3'd2, 5'd21, 5'd0, 12'd16));
		imem.push_back(iType(opLoad, 3'd1, 5'd22, 5'd0, 12'd16));
		imem.push_back(iType(opLoad, 3'd5, 5'd23, 5'd0, 12'd16));
		imem.push_back(iType(opLoad, 3'd0, 5'd24, 5'd0, 12'd23));
		imem.push_back(iType(opLoad, 3'd4, 5'd25, 5'd0, 12'd17));
		imem.push_back(rType(7'h00, 3'd6, 5'd26, 5'd22, 5'd23));
		imem.push_back(bType(5'd1, 5'd3, 13'd8));  // not taken
		imem.push_back(bType(5'd1, 5'd20, 13'd8)); // taken
		imem.push_back(iType(opImm, 3'd0, 5'd27, 5'd0, 12'd99));
		imem.push_back(jType(5'd28, 21'd8));
		imem.push_back(iType(opImm, 3'd0, 5'd27, 5'd0, 12'd77));
		imem.push_back(rType(7'h00, 3'd0, 5'd29, 5'd28, 5'd0)); // link value
		// odd jalr target, lands three slots on
		base = imem.size();
		imem.push_back(iType(opImm, 3'd0, 5'd30, 5'd0, 12'(RESET_PC + 4 * (base + 3) + 1)));
		imem.push_back(iType(opJalr, 3'd0, 5'd31, 5'd30, 12'd0));
		imem.push_back(iType(opImm, 3'd0, 5'd27, 5'd0, 12'd55));
		imem.push_back(rType(7'h00, 3'd0, 5'd27, 5'd31, 5'd0));
		imem.push_back(32'h0000_0000);
		imem.push_back(iType(opImm, 3'd1, 5'd5, 5'd1, 12'd2)); // slli is outside the subset
		imem.push_back(rType(7'h01, 3'd0, 5'd5, 5'd1, 5'd2)); // so is mul
		imem.push_back(sType(3'd3, 5'd1, 5'd0, 12'd16));
		imem.push_back(rType(7'h00, 3'd0, 5'd27, 5'd5, 5'd0));
		imem.push_back(iType(opLoad, 3'd2, 5'd6, 5'd0, 12'd16));
		repeat (randomCount)
			imem.push_back(randomInst());
		imem.push_back(ebreakWord);
	endtask

	function automatic logic [XLEN-1:0] fetchInst(input logic [XLEN-1:0] addr);
		logic [XLEN-1:0] idx;
		idx = (addr - RESET_PC) >> 2;
		if (idx < imem.size())
			return imem[idx];
		else
			return '0;
	endfunction

	function automatic logic [XLEN-1:0] readMemWord(input logic [7:0] a);
		return {dmem[a + 8'd3], dmem[a + 8'd2], dmem[a + 8'd1], dmem[a]};
	endfunction

	// aluResult settles after the new inst, so data follows a little later
	always @(negedge clk) begin
		inst <= fetchInst(pc);
		#1 readData <= readMemWord(aluResult[7:0]);
	end

	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			dmem[aluResult[7:0]] = storeData[7:0];
			if (dataLen != 2'd0)
				dmem[aluResult[7:0] + 8'd1] = storeData[15:8];
			if (dataLen == 2'd3) begin
				dmem[aluResult[7:0] + 8'd2] = storeData[23:16];
				dmem[aluResult[7:0] + 8'd3] = storeData[31:24];
			end
		end
	end

	initial begin
		int cycles;
		int frozen;
		int limit;
		int timeouts;
		int assertFails;
		rst = 1'b1;
		inst = '0;
		readData = '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = 8'(i * 37) ^ 8'h5c;
		loadProgram();
		limit = imem.size() + 20;
		cycles = 0;
		frozen = 0;
		timeouts = 0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		while (frozen < 3 && cycles < limit) begin
			@(posedge clk);
			cycles++;
			if (ebreak === 1'b1)
				frozen++;
		end
		@(negedge clk);
		if (frozen < 3) begin
			$display("Timeout: core did not halt on ebreak within %0d cycles", limit);
			timeouts = 1;
		end
		assertFails = dut_i.props_i.assertFails;
		$display("Done: %0d value errors, %0d assertion failures, %0d timeouts",
			errorCount, assertFails, timeouts);
		if (errorCount == 0 && assertFails == 0 && timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== src.f ====
logic/rvPkg.sv
logic/ctrlPkg.sv
logic/ctrlIf.sv
logic/decoder.sv
logic/pcCounter.sv
logic/regFile.sv
logic/alu.sv
logic/writeBack.sv
logic/rvCore.sv
tb/rvCore_props.sv
tb/coreChecker.sv
tb/rvCore_tb.sv
